//--- mix_ldst_top.f
+incdir+include
logic/mix_pkg.sv
logic/field_extract.sv
logic/field_insert.sv
logic/word_memory.sv
logic/load_store_unit.sv
logic/mix_ldst_top.sv
testbench/mix_ldst_tb.sv

//--- Makefile
TOP   = mix_ldst_tb
FLIST = mix_ldst_top.f

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f $(FLIST) --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/mix_ldst_tb.sv
// Testbench for the MIX load/store top, table driven against a behavioral model

`default_nettype none

`include "mix_config.svh"

module mix_ldst_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import mix_pkg::*;

	typedef struct packed {
		mix_op_t    op;
		mix_addr_t  addr;
		mix_field_t field;
		logic       preload;
		logic       poke;      // Extra start pulse while busy
		mix_word_t  data;
	} step_t;

	logic       clk;
	logic       arst_n;
	logic       host_we;
	mix_addr_t  host_addr;
	mix_word_t  host_wdata;
	logic       start;
	mix_op_t    op;
	mix_addr_t  addr;
	mix_field_t field;
	mix_word_t  reg_a;
	mix_word_t  reg_x;
	logic       busy;
	logic       done;

	step_t      steps[$];
	mix_word_t  model_mem [`MIX_MEM_WORDS];
	mix_word_t  model_a;
	mix_word_t  model_x;
	int         errors;
	int         seed;
	logic       table_ready;

	mix_ldst_top i_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.start      (start),
		.op         (op),
		.addr       (addr),
		.field      (field),
		.reg_a      (reg_a),
		.reg_x      (reg_x),
		.busy       (busy),
		.done       (done)
	);

	always #20 clk = ~clk;

	// ********************
	// Reference model
	// ********************

	function automatic logic in_range(input mix_field_t f);
		return (f[5:3] <= f[2:0]) && (f[2:0] <= 3'd5);
	endfunction

	function automatic mix_field_t fld(input int l, input int r);
		return mix_field_t'(l * 8 + r);
	endfunction

	function automatic mix_word_t model_extract(input mix_word_t w, input mix_field_t f);
		int l;
		int r;
		mix_word_t v;
		l = int'(f[5:3]);
		r = int'(f[2:0]);
		v = '0;
		if (!in_range(f)) begin
			return '0;
		end
		for (int b = (l == 0) ? 1 : l; b <= r; b++) begin
			v = {1'b0, v[23:0], w[(5 - b) * 6 +: 6]};   // Shift in byte b
		end
		if (l == 0) begin
			v[30] = w[30];
		end
		return v;
	endfunction

	// Rightmost bytes of src fill the field from its right end
	function automatic mix_word_t model_insert(input mix_word_t old, input mix_word_t src,
			input mix_field_t f);
		int l;
		int r;
		int lo;
		mix_word_t w;
		l = int'(f[5:3]);
		r = int'(f[2:0]);
		w = old;
		if (!in_range(f)) begin
			return old;
		end
		lo = (l == 0) ? 1 : l;
		for (int k = 0; r - k >= lo; k++) begin
			w[(k + 5 - r) * 6 +: 6] = src[k * 6 +: 6];
		end
		if (l == 0) begin
			w[30] = src[30];
		end
		return w;
	endfunction

	task automatic apply_model(input step_t s);
		mix_word_t v;
		v = model_extract(model_mem[s.addr], s.field);
		case (s.op)
			OP_LDA:  model_a = v;
			OP_LDX:  model_x = v;
			OP_LDAN: model_a = {in_range(s.field), v[29:0]};   // Minus unless invalid
			OP_STA:  model_mem[s.addr] = model_insert(model_mem[s.addr], model_a, s.field);
			OP_STX:  model_mem[s.addr] = model_insert(model_mem[s.addr], model_x, s.field);
			default: model_mem[s.addr] = model_insert(model_mem[s.addr], '0, s.field);
		endcase
	endtask

	// ********************
	// Stimulus table
	// ********************

	task automatic add_step(input mix_op_t s_op, input int s_addr, input mix_field_t s_field,
			input logic s_preload, input logic s_poke);
		step_t s;
		logic [31:0] rnd;
		rnd = $random(seed);
		s.op      = s_op;
		s.addr    = mix_addr_t'(s_addr);
		s.field   = s_field;
		s.preload = s_preload;
		s.poke    = s_poke;
		s.data    = rnd[30:0];
		steps.push_back(s);
	endtask

	task automatic pick_field(output mix_field_t f);
		logic [31:0] rnd;
		int r;
		rnd = $random(seed);
		r = int'(rnd[7:0]) % 6;
		f = fld(int'(rnd[15:8]) % (r + 1), r);
	endtask

	task automatic build_table();
		int n;
		mix_field_t f;
		logic [31:0] rnd;
		mix_op_t st_op;
		n = 0;
		for (int l = 0; l <= 5; l++) begin
			for (int r = l; r <= 5; r++) begin
				add_step(OP_LDA, n, fld(l, r), 1'b1, (n % 5) == 2);
				add_step(OP_LDX, n + 1, fld(l, r), 1'b1, 1'b0);
				n += 2;
			end
		end
		add_step(OP_LDAN, 42, fld(0, 5), 1'b1, 1'b1);
		add_step(OP_LDAN, 43, fld(1, 5), 1'b1, 1'b0);
		add_step(OP_LDAN, 44, fld(0, 0), 1'b1, 1'b0);
		add_step(OP_LDAN, 45, fld(3, 3), 1'b1, 1'b0);
		add_step(OP_LDAN, 46, fld(2, 4), 1'b1, 1'b0);
		// Store with a random field, then read the word back whole
		for (int i = 0; i < 12; i++) begin
			rnd = $random(seed);
			pick_field(f);
			case (i % 3)
				0:       st_op = OP_STA;
				1:       st_op = OP_STX;
				default: st_op = OP_STZ;
			endcase
			add_step(OP_LDA, 48, fld(0, 5), 1'b1, 1'b0);
			add_step(OP_LDX, 49, fld(0, 5), 1'b1, 1'b0);
			add_step(st_op, int'(rnd[5:0]), f, 1'b1, (i % 4) == 1);
			add_step(OP_LDA, int'(rnd[5:0]), fld(0, 5), 1'b0, 1'b0);
		end
		add_step(OP_LDA, 20, fld(3, 1), 1'b1, 1'b0);   // Invalid fields
		add_step(OP_LDX, 21, fld(5, 4), 1'b1, 1'b0);
		add_step(OP_LDAN, 22, fld(0, 6), 1'b1, 1'b0);
		add_step(OP_LDA, 23, fld(2, 7), 1'b1, 1'b0);
		add_step(OP_LDX, 24, fld(7, 7), 1'b1, 1'b0);
		add_step(OP_LDA, 25, fld(0, 5), 1'b1, 1'b0);
		add_step(OP_LDX, 26, fld(0, 5), 1'b1, 1'b0);
		add_step(OP_STA, 30, fld(4, 2), 1'b1, 1'b0);
		add_step(OP_LDX, 30, fld(0, 5), 1'b0, 1'b0);
		add_step(OP_STX, 31, fld(1, 6), 1'b1, 1'b0);
		add_step(OP_LDA, 31, fld(0, 5), 1'b0, 1'b0);
		add_step(OP_STZ, 32, fld(6, 5), 1'b1, 1'b1);
		add_step(OP_LDA, 32, fld(0, 5), 1'b0, 1'b0);
	endtask

	// ********************
	// Step execution
	// ********************

	task automatic run_step(input step_t s);
		int cycles;
		if (s.preload) begin
			host_we    = 1'b1;
			host_addr  = s.addr;
			host_wdata = s.data;
			model_mem[s.addr] = s.data;
			@(negedge clk);
			host_we = 1'b0;
		end
		start = 1'b1;
		op    = s.op;
		addr  = s.addr;
		field = s.field;
		@(negedge clk);
		start  = 1'b0;
		cycles = 1;
		if (s.poke) begin
			start = 1'b1;   // Must be ignored
			op    = (s.op == OP_LDX) ? OP_LDA : OP_LDX;
			addr  = s.addr ^ mix_addr_t'(1);
			field = fld(0, 5);
		end
		while (!done && cycles < 8) begin
			assert (busy === 1'b1) else begin
				errors++;
				$display("mismatch at %0t: busy %b while the operation runs", $time, busy);
			end
			@(negedge clk);
			start = 1'b0;
			cycles++;
		end
		if (!done) begin
			errors++;
			$display("error at %0t: done did not arrive within 8 cycles", $time);
			return;
		end
		assert (cycles == 3) else begin
			errors++;
			$display("mismatch at %0t: done after %0d cycles, expected 3", $time, cycles);
		end
		apply_model(s);
		assert (reg_a === model_a) else begin
			errors++;
			$display("mismatch at %0t: op %0d addr %0d field %o reg_a %h expected %h",
				$time, s.op, s.addr, s.field, reg_a, model_a);
		end
		assert (reg_x === model_x) else begin
			errors++;
			$display("mismatch at %0t: op %0d addr %0d field %o reg_x %h expected %h",
				$time, s.op, s.addr, s.field, reg_x, model_x);
		end
		@(negedge clk);
		assert (done === 1'b0 && busy === 1'b0) else begin
			errors++;
			$display("mismatch at %0t: done %b busy %b after the done cycle", $time, done, busy);
		end
	endtask

	// ********************
	// Main sequence
	// ********************

	initial begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		host_we     = 1'b0;
		host_addr   = '0;
		host_wdata  = '0;
		start       = 1'b0;
		op          = OP_LDA;
		addr        = '0;
		field       = '0;
		errors      = 0;
		seed        = 32'hfc55_90fc;
		model_a     = '0;
		model_x     = '0;
		table_ready = 1'b0;
		for (int i = 0; i < `MIX_MEM_WORDS; i++) begin
			model_mem[i] = '0;
		end
		build_table();
		table_ready = 1'b1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		assert ({reg_a, reg_x, busy, done} === '0) else begin
			errors++;
			$display("mismatch at %0t: reset state reg_a %h reg_x %h busy %b done %b",
				$time, reg_a, reg_x, busy, done);
		end
		arst_n = 1'b1;
		@(negedge clk);
		foreach (steps[i]) begin
			run_step(steps[i]);
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Budget of 8 cycles per step on top of reset
	initial begin
		int limit;
		wait (table_ready === 1'b1);
		limit = (steps.size() * 8 + 16) * 40;
		#(limit);
		$display("timeout: run did not finish within %0d ns", limit);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/mix_ldst_top.sv
// MIX load/store top with the sequencer, word memory and host preload path

`default_nettype none

module mix_ldst_top (
	input  wire logic                clk,
	input  wire logic                arst_n,
	input  wire logic                host_we,
	input  wire mix_pkg::mix_addr_t  host_addr,
	input  wire mix_pkg::mix_word_t  host_wdata,
	input  wire logic                start,
	input  wire mix_pkg::mix_op_t    op,
	input  wire mix_pkg::mix_addr_t  addr,
	input  wire mix_pkg::mix_field_t field,
	output mix_pkg::mix_word_t       reg_a,
	output mix_pkg::mix_word_t       reg_x,
	output logic                     busy,
	output logic                     done
);
	import mix_pkg::*;

	mix_addr_t unit_addr;
	mix_addr_t mem_addr;
	logic      unit_we;
	logic      mem_we;
	mix_word_t unit_wdata;
	mix_word_t mem_wdata;
	mix_word_t mem_rdata;

	load_store_unit i_lsu (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (start),
		.op        (op),
		.addr      (addr),
		.field     (field),
		.mem_addr  (unit_addr),
		.mem_we    (unit_we),
		.mem_wdata (unit_wdata),
		.mem_rdata (mem_rdata),
		.reg_a     (reg_a),
		.reg_x     (reg_x),
		.busy      (busy),
		.done      (done)
	);

	// Host owns the memory while the unit is idle
	assign mem_addr  = busy ? unit_addr  : host_addr;
	assign mem_we    = busy ? unit_we    : host_we;
	assign mem_wdata = busy ? unit_wdata : host_wdata;

	word_memory i_mem (
		.clk   (clk),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

endmodule

`default_nettype wire

//--- logic/load_store_unit.sv
// Load/store sequencer with registers A and X over a MIX word memory

`default_nettype none

module load_store_unit (
	input  wire logic                clk,
	input  wire logic                arst_n,
	input  wire logic                start,
	input  wire mix_pkg::mix_op_t    op,
	input  wire mix_pkg::mix_addr_t  addr,
	input  wire mix_pkg::mix_field_t field,
	output mix_pkg::mix_addr_t       mem_addr,
	output logic                     mem_we,
	output mix_pkg::mix_word_t       mem_wdata,
	input  wire mix_pkg::mix_word_t  mem_rdata,
	output mix_pkg::mix_word_t       reg_a,
	output mix_pkg::mix_word_t       reg_x,
	output logic                     busy,
	output logic                     done
);
	import mix_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_EXEC,
		ST_FINISH
	} state_t;

	state_t     state;
	mix_op_t    op_q;
	mix_addr_t  addr_q;
	mix_field_t field_q;
	mix_word_t  extracted;
	mix_word_t  store_src;
	mix_word_t  load_val;
	logic       field_ok;
	logic       is_store;

	// ********************
	// Sequencer
	// ********************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_READ;
					end
				end
				ST_READ: begin
					state <= ST_EXEC;   // Memory word lands here
				end
				ST_EXEC: begin
					state <= ST_FINISH;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Request is held for the whole operation
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start) begin
			op_q    <= op;
			addr_q  <= addr;
			field_q <= field;
		end
	end

	assign busy = (state != ST_IDLE);
	assign done = (state == ST_FINISH);

	// ********************
	// Field datapath
	// ********************

	field_extract i_extract (
		.word  (mem_rdata),
		.field (field_q),
		.value (extracted)
	);

	field_insert i_insert (
		.old_word (mem_rdata),
		.source   (store_src),
		.field    (field_q),
		.new_word (mem_wdata),
		.field_ok (field_ok)
	);

	always_comb begin
		case (op_q)
			OP_STA: begin
				store_src = reg_a;
			end
			OP_STX: begin
				store_src = reg_x;
			end
			default: begin
				store_src = '0;   // STZ
			end
		endcase
	end

	assign is_store = (op_q == OP_STA) || (op_q == OP_STX) || (op_q == OP_STZ);

	// Invalid field stays at plus zero even for LDAN
	assign load_val = {extracted[30] | (op_q == OP_LDAN && field_ok), extracted[29:0]};

	assign mem_addr = addr_q;
	assign mem_we   = (state == ST_EXEC) && is_store && field_ok;

	// ********************
	// Registers A and X
	// ********************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reg_a <= '0;
			reg_x <= '0;
		end else if (state == ST_EXEC) begin
			case (op_q)
				OP_LDA, OP_LDAN: begin
					reg_a <= load_val;
				end
				OP_LDX: begin
					reg_x <= load_val;
				end
				default: begin
				end
			endcase
		end
	end

	// ********************
	// Checks
	// ********************

	a_done_pulse: assert property (
		@(posedge clk) disable iff (!arst_n) done |=> !done
	) else $error("done longer than one cycle");

	// The write slot is the EXEC cycle, two cycles after the accepted start
	a_we_in_exec: assert property (
		@(posedge clk) disable iff (!arst_n) mem_we |-> $past(state == ST_IDLE && start, 2)
	) else $error("memory write outside EXEC");

	// Busy rises alone and done follows two cycles later
	a_busy_then_done: assert property (
		@(posedge clk) disable iff (!arst_n) $rose(busy) |-> !done ##2 done
	) else $error("busy and done out of order");

endmodule

`default_nettype wire

//--- logic/word_memory.sv
// Word memory with one synchronous read port and a write port

`default_nettype none

`include "mix_config.svh"

module word_memory (
	input  wire logic               clk,
	input  wire logic               we,
	input  wire mix_pkg::mix_addr_t addr,
	input  wire mix_pkg::mix_word_t wdata,
	output mix_pkg::mix_word_t      rdata
);
	import mix_pkg::*;

	mix_word_t mem [`MIX_MEM_WORDS];

	// ********************
	// Storage
	// ********************

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];   // Old data on a same-cycle write
	end

	// ********************
	// Checks
	// ********************

	// A write to an unknown address would corrupt an unknown word
	a_we_addr_known: assert property (
		@(posedge clk) we |-> !$isunknown(addr)
	) else $error("write with unknown address");

endmodule

`default_nettype wire

//--- logic/field_insert.sv
// Field inserter that merges low bytes of a register into field L..R of a word

`default_nettype none

module field_insert (
	input  wire mix_pkg::mix_word_t  old_word,
	input  wire mix_pkg::mix_word_t  source,
	input  wire mix_pkg::mix_field_t field,
	output mix_pkg::mix_word_t       new_word,
	output logic                     field_ok
);
	import mix_pkg::*;

	localparam int BYTE_W = 6;

	logic [2:0] fl;
	logic [2:0] fr;

	assign fl = field[5:3];
	assign fr = field[2:0];

	// ********************
	// Field check
	// ********************

	assign field_ok = (fl <= fr) && (fr <= 3'd5);

	// ********************
	// Byte merge
	// ********************

	// Byte p of the result takes source byte p+5-R, the rightmost ones
	always_comb begin
		mix_byte_t src_byte;
		int k;
		new_word = old_word;
		src_byte = '0;
		k = 0;
		if (field_ok) begin
			if (fl == 3'd0) begin
				new_word[30] = source[30];
			end
			for (int p = 1; p <= 5; p++) begin
				if (p >= int'(fl) && p <= int'(fr)) begin
					k = p + 5 - int'(fr);
					src_byte = source[(30 - BYTE_W * k) +: BYTE_W];
					new_word[(30 - BYTE_W * p) +: BYTE_W] = src_byte;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/field_extract.sv
// Field extractor that returns bytes L..R of a MIX word right-justified

`default_nettype none

module field_extract (
	input  wire mix_pkg::mix_word_t  word,
	input  wire mix_pkg::mix_field_t field,
	output mix_pkg::mix_word_t       value
);
	import mix_pkg::*;

	localparam int BYTE_W = 6;

	logic [2:0] fl;   // Left boundary
	logic [2:0] fr;   // Right boundary
	mix_word_t cand [6];

	// All ones in the low nbytes byte lanes
	function automatic logic [29:0] byte_mask(input int nbytes);
		return ~({30{1'b1}} << (BYTE_W * nbytes));
	endfunction

	assign fl = field[5:3];
	assign fr = field[2:0];

	// ********************
	// Candidates per R
	// ********************

	// Each candidate assumes its own R and picks bytes by L
	always_comb begin
		logic [29:0] bytes_r;   // Bytes 1..r, byte r in the low lane
		for (int r = 0; r < 6; r++) begin
			bytes_r = word[29:0] >> (BYTE_W * (5 - r));
			if (fl == 3'd0) begin
				// Sign travels only when L is 0
				cand[r] = {word[30], bytes_r & byte_mask(r)};
			end else if (int'(fl) > r) begin
				cand[r] = '0;   // L past R
			end else begin
				cand[r] = {1'b0, bytes_r & byte_mask(r - int'(fl) + 1)};
			end
		end
	end

	// ********************
	// Select by R
	// ********************

	always_comb begin
		case (fr)
			3'd0: begin
				value = cand[0];
			end
			3'd1: begin
				value = cand[1];
			end
			3'd2: begin
				value = cand[2];
			end
			3'd3: begin
				value = cand[3];
			end
			3'd4: begin
				value = cand[4];
			end
			3'd5: begin
				value = cand[5];
			end
			default: begin
				value = '0;   // R beyond byte 5
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/mix_pkg.sv
// MIX load/store package with the word, byte, field, address and op types

`default_nettype none

`include "mix_config.svh"

package mix_pkg;

	// ********************
	// Data formats
	// ********************

	typedef logic [30:0] mix_word_t;   // Sign in bit 30, bytes 1..5 below
	typedef logic [5:0]  mix_byte_t;
	typedef logic [5:0]  mix_field_t;  // L in 5:3, R in 2:0

	typedef logic [`MIX_ADDR_BITS-1:0] mix_addr_t;

	// ********************
	// Operations
	// ********************

	typedef enum logic [2:0] {
		OP_LDA  = 3'd0,
		OP_LDX  = 3'd1,
		OP_LDAN = 3'd2,
		OP_STA  = 3'd3,
		OP_STX  = 3'd4,
		OP_STZ  = 3'd5
	} mix_op_t;

endpackage

`default_nettype wire

//--- include/mix_config.svh
// MIX load/store configuration, memory address width and depth

`ifndef MIX_CONFIG_SVH
`define MIX_CONFIG_SVH

// ********************
// Memory geometry
// ********************

// Word address width
`define MIX_ADDR_BITS 6

// Number of words, always a power of two
`define MIX_MEM_WORDS (1 << `MIX_ADDR_BITS)

`endif
